/* Bender.yml */
package:
  name: mcntrl_test

export_include_dirs:
  - .

sources:
  - mcntrl_test_pkg.sv
  - cmd_deser.sv
  - frame_chn_ctrl.sv
  - status_generate.sv
  - status_router.sv
  - mcntrl_test.sv
  - target: simulation
    files:
      - tb_mcntrl_test.sv

/* cmd_deser.sv */
`timescale 1ns/1ns
`include "mcntrl_test_cfg.svh"

module cmd_deser (
    input  logic                       mclk,
    input  logic                       rst,
    input  mcntrl_test_pkg::byte_t     ad,
    input  logic                       stb,
    output mcntrl_test_pkg::reg_addr_t addr,
    output mcntrl_test_pkg::byte_t     data,
    output logic                       we
);

    localparam logic [15:0] WIN_ADDR = `MCNTRL_TEST_ADDR;
    localparam logic [15:0] WIN_MASK = `MCNTRL_TEST_MASK;

    logic [1:0]  phase;      // 0 idle, 1 got AL, 2 got AH
    logic [15:0] addr_sr;    // {AH, AL} once phase reaches 2
    logic        addr_match;

    assign addr_match = ((addr_sr & WIN_MASK) == (WIN_ADDR & WIN_MASK));

    // byte shifter, new byte enters at the top
    always_ff @(posedge mclk) begin
        addr_sr <= {ad, addr_sr[15:8]};
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            phase <= 2'd0;
            we    <= 1'b0;
        end else begin
            if (stb) begin
                phase <= 2'd1;                // AL is on the bus now
            end else if (phase == 2'd2) begin
                phase <= 2'd0;
            end else if (phase != 2'd0) begin
                phase <= phase + 2'd1;
            end
            we <= (phase == 2'd2) && addr_match;
        end
    end

    // D0 on the bus while phase is 2
    always_ff @(posedge mclk) begin
        if (phase == 2'd2) begin
            addr <= addr_sr[3:0];
            data <= ad;
        end
    end

endmodule

/* frame_chn_ctrl.sv */
`timescale 1ns/1ns

module frame_chn_ctrl (
    input  logic                   mclk,
    input  logic                   rst,
    input  logic                   mode_we,
    input  mcntrl_test_pkg::byte_t cmd_data,
    input  logic                   page_ready,
    input  logic                   frame_done,
    output logic                   frame_start,
    output logic                   next_page,
    output logic                   suspend,
    output mcntrl_test_pkg::page_t page,
    output logic                   busy,
    output logic                   finished
);

    // mode register write, pulses and suspend level
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            frame_start <= 1'b0;
            next_page   <= 1'b0;
            suspend     <= 1'b0;
        end else begin
            frame_start <= mode_we && cmd_data[0];
            next_page   <= mode_we && cmd_data[1];
            if (mode_we) begin
                suspend <= cmd_data[2];
            end
        end
    end

    // pages completed in the current frame
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            page <= '0;
        end else if (frame_start) begin
            page <= '0;
        end else if (page_ready) begin
            page <= page + 1'b1;              // wraps at 16
        end
    end

    // frame_start and frame_done together leave both flags as they are
    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            finished <= 1'b0;
        end else if (frame_start && !frame_done) begin
            busy     <= 1'b1;
            finished <= 1'b0;
        end else if (!frame_start && frame_done) begin
            busy     <= 1'b0;
            finished <= 1'b1;
        end
    end

endmodule

/* mcntrl_test.f */
+incdir+.
mcntrl_test_pkg.sv
cmd_deser.sv
frame_chn_ctrl.sv
status_generate.sv
status_router.sv
mcntrl_test.sv
tb_mcntrl_test.sv

/* mcntrl_test.sv */
`timescale 1ns/1ns
`include "mcntrl_test_cfg.svh"

module mcntrl_test (
    input  logic                                        mclk,
    input  logic                                        rst,
    input  mcntrl_test_pkg::byte_t                      cmd_ad,
    input  logic                                        cmd_stb,
    input  logic                                        status_start,
    input  logic [`MCNTRL_NUM_CHN-1:0]                  page_ready,
    input  logic [`MCNTRL_NUM_CHN-1:0]                  frame_done,
    input  mcntrl_test_pkg::line_t [`MCNTRL_NUM_CHN-1:0] line_unfinished,
    output mcntrl_test_pkg::byte_t                      status_ad,
    output logic                                        status_rq,
    output logic [`MCNTRL_NUM_CHN-1:0]                  frame_start,
    output logic [`MCNTRL_NUM_CHN-1:0]                  next_page,
    output logic [`MCNTRL_NUM_CHN-1:0]                  suspend
);

    localparam int NUM_CHN = `MCNTRL_NUM_CHN;

    logic                                cmd_we;
    mcntrl_test_pkg::reg_addr_t          cmd_a;
    mcntrl_test_pkg::byte_t              cmd_data;
    mcntrl_test_pkg::byte_t [NUM_CHN-1:0] chn_ad;
    logic [NUM_CHN-1:0]                  chn_rq;
    logic [NUM_CHN-1:0]                  chn_start;

    cmd_deser cmd_deser_i (
        .mclk (mclk),
        .rst  (rst),
        .ad   (cmd_ad),
        .stb  (cmd_stb),
        .addr (cmd_a),
        .data (cmd_data),
        .we   (cmd_we)
    );

    for (genvar i = 0; i < NUM_CHN; i++) begin : g_chn
        logic                             mode_we;
        logic                             status_we;
        mcntrl_test_pkg::page_t           page;
        logic                             busy;
        logic                             finished;
        mcntrl_test_pkg::status_payload_t status;

        // two register codes per channel
        assign mode_we   = cmd_we &&
            (cmd_a == mcntrl_test_pkg::reg_addr_t'(`MCNTRL_MODE_BASE + 2 * i));
        assign status_we = cmd_we &&
            (cmd_a == mcntrl_test_pkg::reg_addr_t'(`MCNTRL_MODE_BASE + 2 * i + 1));

        assign status = {page, line_unfinished[i], finished, busy};

        frame_chn_ctrl frame_chn_ctrl_i (
            .mclk        (mclk),
            .rst         (rst),
            .mode_we     (mode_we),
            .cmd_data    (cmd_data),
            .page_ready  (page_ready[i]),
            .frame_done  (frame_done[i]),
            .frame_start (frame_start[i]),
            .next_page   (next_page[i]),
            .suspend     (suspend[i]),
            .page        (page),
            .busy        (busy),
            .finished    (finished)
        );

        status_generate #(
            .STATUS_REG_ADDR (mcntrl_test_pkg::byte_t'(`MCNTRL_STATUS_ADDR_BASE + i))
        ) status_generate_i (
            .mclk   (mclk),
            .rst    (rst),
            .we     (status_we),
            .wd     (cmd_data),
            .status (status),
            .start  (chn_start[i]),
            .ad     (chn_ad[i]),
            .rq     (chn_rq[i])
        );
    end

    status_router status_router_i (
        .mclk      (mclk),
        .rst       (rst),
        .db_in     (chn_ad),
        .rq_in     (chn_rq),
        .start_out (status_start),
        .start_in  (chn_start),
        .db_out    (status_ad),
        .rq_out    (status_rq)
    );

endmodule

/* mcntrl_test_cfg.svh */
`ifndef MCNTRL_TEST_CFG_SVH
`define MCNTRL_TEST_CFG_SVH

// command address window
`define MCNTRL_TEST_ADDR 16'h00f0
`define MCNTRL_TEST_MASK 16'h03f0

// number of frame channels
`define MCNTRL_NUM_CHN 2

// payload field widths
`define MCNTRL_FRAME_HEIGHT_BITS 16
`define MCNTRL_PAGE_BITS 4

// channel n mode register is base + 2n, status control is one above
`define MCNTRL_MODE_BASE 4

// channel n status packet address is base + n
`define MCNTRL_STATUS_ADDR_BASE 8'h3c

// address byte plus four data bytes
`define MCNTRL_STATUS_BYTES 5

`endif

/* mcntrl_test_pkg.sv */
`include "mcntrl_test_cfg.svh"

package mcntrl_test_pkg;

    typedef logic [7:0] byte_t;                              // command/status byte lane
    typedef logic [3:0] reg_addr_t;                          // register code in the window
    typedef logic [`MCNTRL_FRAME_HEIGHT_BITS-1:0] line_t;    // unfinished line count
    typedef logic [`MCNTRL_PAGE_BITS-1:0] page_t;            // pages done, wraps

    // packed per-channel status, msb first
    typedef struct packed {
        page_t page;
        line_t lines;
        logic  finished;
        logic  busy;
    } status_payload_t;

    typedef enum logic [1:0] {
        OFF    = 2'd0,
        SINGLE = 2'd1,   // one packet, then back to off
        AUTO   = 2'd3    // packet on every payload change
    } status_mode_t;

endpackage

/* status_generate.sv */
`timescale 1ns/1ns
`include "mcntrl_test_cfg.svh"

module status_generate #(
    parameter mcntrl_test_pkg::byte_t STATUS_REG_ADDR = 8'h3c
) (
    input  logic                             mclk,
    input  logic                             rst,
    input  logic                             we,
    input  mcntrl_test_pkg::byte_t           wd,
    input  mcntrl_test_pkg::status_payload_t status,
    input  logic                             start,
    output mcntrl_test_pkg::byte_t           ad,
    output logic                             rq
);

    localparam int CNT_BITS = $clog2(`MCNTRL_STATUS_BYTES);
    localparam logic [CNT_BITS-1:0] LAST_BYTE = CNT_BITS'(`MCNTRL_STATUS_BYTES - 1);

    mcntrl_test_pkg::status_mode_t    mode;
    logic [5:0]                       seq;
    mcntrl_test_pkg::status_payload_t sent;      // payload of the latest packet
    logic [CNT_BITS-1:0]              byte_cnt;  // 0 idle, 1..4 data bytes
    logic                             can_rq;
    logic                             single_wr;
    logic                             trigger;

    // no new request while one is pending or a packet is going out
    assign can_rq    = !rq && (byte_cnt == '0);
    assign single_wr = we && (wd[7:6] == 2'b01);   // requests in the write cycle
    assign trigger   = can_rq && (single_wr || (mode == mcntrl_test_pkg::SINGLE) ||
                                  ((mode == mcntrl_test_pkg::AUTO) && (status != sent)));

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            mode     <= mcntrl_test_pkg::OFF;
            seq      <= '0;
            sent     <= '0;
            byte_cnt <= '0;
            rq       <= 1'b0;
        end else begin
            if (we) begin
                case (wd[7:6])
                    2'b01:   mode <= can_rq ? mcntrl_test_pkg::OFF   // served at once
                                            : mcntrl_test_pkg::SINGLE;
                    2'b11:   mode <= mcntrl_test_pkg::AUTO;
                    default: mode <= mcntrl_test_pkg::OFF;
                endcase
                seq <= wd[5:0];
            end else if (trigger && (mode == mcntrl_test_pkg::SINGLE)) begin
                mode <= mcntrl_test_pkg::OFF;   // single shot done
            end

            if (trigger) begin
                rq <= 1'b1;
            end else if (start) begin
                rq <= 1'b0;
            end

            if (start) begin
                sent     <= status;             // snapshot at start
                byte_cnt <= CNT_BITS'(1);
            end else if (byte_cnt == LAST_BYTE) begin
                byte_cnt <= '0;
            end else if (byte_cnt != '0) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

    // address byte while idle or requesting, then the snapshot
    always_comb begin
        case (byte_cnt)
            CNT_BITS'(1): ad = {seq, sent[1:0]};
            CNT_BITS'(2): ad = sent[9:2];
            CNT_BITS'(3): ad = sent[17:10];
            CNT_BITS'(4): ad = {4'h0, sent[21:18]};
            default:      ad = STATUS_REG_ADDR;
        endcase
    end

endmodule

/* status_router.sv */
`timescale 1ns/1ns
`include "mcntrl_test_cfg.svh"

module status_router (
    input  logic                                         mclk,
    input  logic                                         rst,
    input  mcntrl_test_pkg::byte_t [`MCNTRL_NUM_CHN-1:0] db_in,
    input  logic [`MCNTRL_NUM_CHN-1:0]                   rq_in,
    input  logic                                         start_out,
    output logic [`MCNTRL_NUM_CHN-1:0]                   start_in,
    output mcntrl_test_pkg::byte_t                       db_out,
    output logic                                         rq_out
);

    localparam int NUM_CHN  = `MCNTRL_NUM_CHN;
    localparam int CHN_BITS = (NUM_CHN > 1) ? $clog2(NUM_CHN) : 1;
    localparam int CNT_BITS = $clog2(`MCNTRL_STATUS_BYTES);
    localparam logic [CNT_BITS-1:0] LAST_BYTE = CNT_BITS'(`MCNTRL_STATUS_BYTES - 1);

    logic [CHN_BITS-1:0] grant;
    logic [CHN_BITS-1:0] last_chn;   // channel served most recently
    logic [CHN_BITS-1:0] next_chn;
    logic                active;     // grant held for a whole packet
    logic [CNT_BITS-1:0] byte_cnt;

    // round robin, nearest requester after last_chn wins
    always_comb begin : rr_pick
        int idx;
        next_chn = last_chn;
        for (int i = NUM_CHN; i >= 1; i--) begin
            idx = int'(last_chn) + i;
            if (idx >= NUM_CHN) begin
                idx = idx - NUM_CHN;
            end
            if (rq_in[idx]) begin
                next_chn = CHN_BITS'(idx);
            end
        end
    end

    assign db_out = db_in[grant];
    assign rq_out = active && rq_in[grant];

    always_comb begin
        start_in        = '0;
        start_in[grant] = rq_out && start_out;   // only the owner sees start
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            active   <= 1'b0;
            grant    <= '0;
            last_chn <= CHN_BITS'(NUM_CHN - 1);   // channel 0 goes first
            byte_cnt <= '0;
        end else if (!active) begin
            if (|rq_in) begin
                active <= 1'b1;
                grant  <= next_chn;
            end
        end else begin
            if (rq_out && start_out) begin
                byte_cnt <= CNT_BITS'(1);
            end else if (byte_cnt == LAST_BYTE) begin
                byte_cnt <= '0;
                active   <= 1'b0;                 // last byte passed
                last_chn <= grant;
            end else if (byte_cnt != '0) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

endmodule

/* tb_mcntrl_test.sv */
`timescale 1ns/1ns
`include "mcntrl_test_cfg.svh"

module tb_mcntrl_test;

    localparam int NUM_CHN    = `MCNTRL_NUM_CHN;
    localparam int MAX_CYCLES = 4000;

    logic                                         mclk = 1'b0;
    logic                                         rst;
    mcntrl_test_pkg::byte_t                       cmd_ad;
    logic                                         cmd_stb;
    logic                                         status_start;
    logic [NUM_CHN-1:0]                           page_ready;
    logic [NUM_CHN-1:0]                           frame_done;
    mcntrl_test_pkg::line_t [NUM_CHN-1:0]         line_unfinished;
    mcntrl_test_pkg::byte_t                       status_ad;
    logic                                         status_rq;
    logic [NUM_CHN-1:0]                           frame_start;
    logic [NUM_CHN-1:0]                           next_page;
    logic [NUM_CHN-1:0]                           suspend;

    // reference model of the channel state
    logic [3:0]         exp_page [NUM_CHN];
    logic [5:0]         exp_seq  [NUM_CHN];
    logic [NUM_CHN-1:0] exp_busy;
    logic [NUM_CHN-1:0] exp_fin;
    logic [NUM_CHN-1:0] exp_susp;

    int          errors    = 0;
    int          checks    = 0;
    int          cycle_cnt = 0;
    int unsigned seed;

    mcntrl_test DUT (
        .mclk            (mclk),
        .rst             (rst),
        .cmd_ad          (cmd_ad),
        .cmd_stb         (cmd_stb),
        .status_start    (status_start),
        .page_ready      (page_ready),
        .frame_done      (frame_done),
        .line_unfinished (line_unfinished),
        .status_ad       (status_ad),
        .status_rq       (status_rq),
        .frame_start     (frame_start),
        .next_page       (next_page),
        .suspend         (suspend)
    );

    always #20 mclk = ~mclk;

    always @(posedge mclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles, checks: %0d, errors: %0d",
                     cycle_cnt, checks, errors);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic compare_val(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // three-byte command AL, AH, D0, pulses checked around S+4
    task automatic send_cmd(input logic [15:0] a, input logic [7:0] d, input logic with_stb);
        logic [NUM_CHN-1:0] exp_fs;
        logic [NUM_CHN-1:0] exp_np;
        logic               hit;
        logic               rq_due;
        hit = with_stb &&
              ((a & `MCNTRL_TEST_MASK) == (`MCNTRL_TEST_ADDR & `MCNTRL_TEST_MASK));
        exp_fs = '0;
        exp_np = '0;
        rq_due = 1'b0;
        @(negedge mclk);
        cmd_stb = with_stb;
        cmd_ad  = a[7:0];
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = a[15:8];
        @(negedge mclk);
        cmd_ad = d;
        @(negedge mclk);
        cmd_ad = 8'h00;
        compare_val("frame_start", frame_start, '0);    // not early
        compare_val("next_page", next_page, '0);
        compare_val("suspend", suspend, exp_susp);
        for (int ch = 0; ch < NUM_CHN; ch++) begin
            if (hit && int'(a[3:0]) == `MCNTRL_MODE_BASE + 2 * ch) begin
                exp_fs[ch]   = d[0];
                exp_np[ch]   = d[1];
                exp_susp[ch] = d[2];
                if (d[0]) begin
                    exp_page[ch] = 4'd0;
                    exp_busy[ch] = 1'b1;
                    exp_fin[ch]  = 1'b0;
                end
            end else if (hit && int'(a[3:0]) == `MCNTRL_MODE_BASE + 2 * ch + 1) begin
                exp_seq[ch] = d[5:0];
                rq_due      = (d[7:6] == 2'b01);
            end
        end
        @(negedge mclk);
        compare_val("frame_start", frame_start, exp_fs);
        compare_val("next_page", next_page, exp_np);
        compare_val("suspend", suspend, exp_susp);
        @(negedge mclk);
        compare_val("frame_start", frame_start, '0);    // one cycle only
        compare_val("next_page", next_page, '0);
        if (rq_due) begin
            compare_val("status_rq", status_rq, 1);     // up by S+5
        end
    endtask

    task automatic pulse_page(input int ch, input int n);
        repeat (n) begin
            @(negedge mclk);
            page_ready[ch] = 1'b1;
            @(negedge mclk);
            page_ready[ch] = 1'b0;
            exp_page[ch] = exp_page[ch] + 4'd1;     // wraps at 16
        end
    endtask

    task automatic pulse_done(input int ch);
        @(negedge mclk);
        frame_done[ch] = 1'b1;
        @(negedge mclk);
        frame_done[ch] = 1'b0;
        exp_busy[ch] = 1'b0;
        exp_fin[ch]  = 1'b1;
    endtask

    // consumer with a random start delay, returns {addr, b1, b2, b3, b4}
    task automatic collect_packet(output logic [39:0] pkt, output logic ok);
        int wait_cnt;
        int delay;
        wait_cnt = 0;
        pkt = '0;
        @(negedge mclk);
        while (!status_rq && wait_cnt < 200) begin
            @(negedge mclk);
            wait_cnt++;
        end
        ok = status_rq;
        if (!ok) begin
            errors++;
            $display("no status request arrived within 200 cycles at t=%0t", $time);
        end else begin
            pkt[39:32] = status_ad;
            delay = $urandom % 8;
            repeat (delay) begin
                @(negedge mclk);
                compare_val("status_rq", status_rq, 1);   // request stays pending
                compare_val("status_ad", status_ad, pkt[39:32]);
            end
            status_start = 1'b1;
            @(negedge mclk);
            status_start = 1'b0;
            pkt[31:24] = status_ad;
            compare_val("status_rq", status_rq, 0);
            @(negedge mclk);
            pkt[23:16] = status_ad;
            @(negedge mclk);
            pkt[15:8] = status_ad;
            @(negedge mclk);
            pkt[7:0] = status_ad;
        end
    endtask

    task automatic verify_packet(input logic [39:0] pkt, output int ch);
        ch = int'(pkt[39:32]) - int'(`MCNTRL_STATUS_ADDR_BASE);
        if (ch < 0 || ch >= NUM_CHN) begin
            errors++;
            $display("status packet with unknown address byte %02h at t=%0t",
                     pkt[39:32], $time);
            ch = -1;
        end else begin
            compare_val($sformatf("status_seq[%0d]", ch), pkt[31:26], exp_seq[ch]);
            compare_val($sformatf("status_finished[%0d]", ch), pkt[25], exp_fin[ch]);
            compare_val($sformatf("status_busy[%0d]", ch), pkt[24], exp_busy[ch]);
            compare_val($sformatf("status_lines[%0d]", ch), {pkt[15:8], pkt[23:16]},
                        line_unfinished[ch]);
            compare_val($sformatf("status_page[%0d]", ch), pkt[7:0], {4'h0, exp_page[ch]});
        end
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            @(negedge mclk);
            compare_val("status_rq", status_rq, 0);
        end
    endtask

    initial begin
        logic [39:0]        pkt;
        logic               ok;
        int                 ch;
        logic [NUM_CHN-1:0] seen;

        seed = 32'hd30b929e;
        void'($urandom(seed));
        rst             = 1'b1;
        cmd_ad          = 8'h00;
        cmd_stb         = 1'b0;
        status_start    = 1'b0;
        page_ready      = '0;
        frame_done      = '0;
        line_unfinished = '0;
        exp_busy        = '0;
        exp_fin         = '0;
        exp_susp        = '0;
        for (int i = 0; i < NUM_CHN; i++) begin
            exp_page[i] = 4'd0;
            exp_seq[i]  = 6'd0;
        end
        repeat (10) @(posedge mclk);
        @(negedge mclk);
        rst = 1'b0;
        compare_val("suspend", suspend, '0);
        compare_val("status_rq", status_rq, 0);

        // window filter and strobe, then pulses on their own channel
        send_cmd(16'h01f4, 8'h07, 1'b1);
        send_cmd(16'h00f4, 8'h07, 1'b0);
        send_cmd(16'h00f6, 8'h06, 1'b1);
        send_cmd(16'h00f4, 8'h03, 1'b1);
        send_cmd(16'h00f4, 8'h04, 1'b1);
        send_cmd(16'h00f6, 8'h00, 1'b1);

        // page count, busy and finished through SINGLE reads
        line_unfinished[0] = 16'h1234;
        line_unfinished[1] = 16'h0a5c;
        send_cmd(16'h00f4, 8'h05, 1'b1);
        send_cmd(16'h00f6, 8'h01, 1'b1);
        pulse_page(0, 18);
        pulse_page(1, 5);
        send_cmd(16'h00f5, 8'h6a, 1'b1);    // SINGLE, seq 2a
        collect_packet(pkt, ok);
        if (ok) verify_packet(pkt, ch);
        pulse_done(0);
        send_cmd(16'h00f5, 8'h51, 1'b1);
        collect_packet(pkt, ok);
        if (ok) verify_packet(pkt, ch);

        // AUTO on channel 1
        send_cmd(16'h00f7, 8'h45, 1'b1);
        collect_packet(pkt, ok);
        if (ok) verify_packet(pkt, ch);
        send_cmd(16'h00f7, 8'hc5, 1'b1);
        expect_quiet(20);
        @(negedge mclk);
        line_unfinished[1] = 16'h0bcd;
        collect_packet(pkt, ok);
        if (ok) verify_packet(pkt, ch);
        expect_quiet(20);
        send_cmd(16'h00f7, 8'h05, 1'b1);    // back to OFF
        @(negedge mclk);
        line_unfinished[1] = 16'h0bce;
        expect_quiet(20);

        // both channels at once, random start delays
        repeat (6) begin
            @(negedge mclk);
            line_unfinished[0] = 16'($urandom);
            line_unfinished[1] = 16'($urandom);
            send_cmd(16'h00f5, {2'b01, 6'($urandom)}, 1'b1);
            send_cmd(16'h00f7, {2'b01, 6'($urandom)}, 1'b1);
            seen = '0;
            repeat (2) begin
                collect_packet(pkt, ok);
                if (ok) begin
                    verify_packet(pkt, ch);
                    if (ch >= 0) seen[ch] = 1'b1;
                end
            end
            compare_val("channels served", seen, {NUM_CHN{1'b1}});
            expect_quiet(4);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
